// ==== list.f ====
+incdir+verilog
verilog/virtio_mmio_pkg.sv
verilog/mmio_axi_slave.sv
verilog/virtio_status_ctrl.sv
verilog/virtio_reg_file.sv
verilog/virtio_mmio_top.sv
tests/tb_clock_gen.sv
tests/tb_virtio_mmio.sv

// ==== run.sh ====
#!/bin/sh
# build and run the virtio-mmio testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f \
	--top-module tb_virtio_mmio -o sim_virtio_mmio
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_virtio_mmio > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic axi_aclk,
	output logic axi_aresetn
);

	localparam int RESET_CYCLES = 8;

	// 40 ns period
	initial
	begin
		axi_aclk = 1'b0;
		forever
			#20 axi_aclk = ~axi_aclk;
	end

	// released just after an edge, like every other input
	initial
	begin
		axi_aresetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge axi_aclk);
		#2;
		axi_aresetn = 1'b1;
	end

endmodule

// ==== tests/tb_virtio_mmio.sv ====
`timescale 1ns/1ps
`include "virtio_mmio_cfg.svh"

module tb_virtio_mmio;

	import virtio_mmio_pkg::*;

	localparam int TIMEOUT = 20;
	localparam int MAX_OPS = 128;

	logic                        axi_aclk;
	logic                        axi_aresetn;
	logic [`VIRTIO_ID_W-1:0]     awid;
	logic [`VIRTIO_ADDR_W-1:0]   awaddr;
	logic                        awvalid;
	logic                        awready;
	logic [`VIRTIO_DATA_W-1:0]   wdata;
	logic [`VIRTIO_DATA_W/8-1:0] wstrb;
	logic                        wvalid;
	logic                        wready;
	logic [`VIRTIO_ID_W-1:0]     bid;
	logic [1:0]                  bresp;
	logic                        bvalid;
	logic                        bready;
	logic [`VIRTIO_ID_W-1:0]     arid;
	logic [`VIRTIO_ADDR_W-1:0]   araddr;
	logic                        arvalid;
	logic                        arready;
	logic [`VIRTIO_ID_W-1:0]     rid;
	logic [`VIRTIO_DATA_W-1:0]   rdata;
	logic [1:0]                  rresp;
	logic                        rlast;
	logic                        rvalid;
	logic                        rready;
	vq_ring_t                    vq0;
	logic                        dev_req;

	// each operation takes four words of kind, address, data and test number
	logic [31:0] stim_mem [0:4*MAX_OPS-1];

	int pulse_cnt;
	int err_cnt;
	int check_cnt;
	int test_cnt;
	int test_fail_cnt;
	int test_err_base;
	int test_chk_base;
	bit timed_out;

	tb_clock_gen i_clk (
		.axi_aclk    (axi_aclk),
		.axi_aresetn (axi_aresetn)
	);

	virtio_mmio_top i_dut (.*);

	// dev_req pulses seen since reset
	always @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			pulse_cnt <= 0;
		else if (dev_req)
			pulse_cnt <= pulse_cnt + 1;
	end

	task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_cnt++;
		assert (act === exp)
		else
		begin
			$display("FAILED %s: expected %08h, got %08h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: no %s within %0d cycles", what, TIMEOUT);
		err_cnt++;
		timed_out = 1'b1;
	endtask

	task automatic write_reg(input logic [11:0] addr, input logic [31:0] data, input logic id);
		int n;
		int hold;
		awid    = id;
		awaddr  = addr;
		awvalid = 1'b1;
		wdata   = data;
		wstrb   = 4'hf;
		wvalid  = 1'b1;
		n = 0;
		do
		begin
			@(posedge axi_aclk);
			n++;
		end
		while (!(awready && wready) && n < TIMEOUT);
		if (!(awready && wready))
			report_timeout("awready and wready");
		else
		begin
			#2;
			awvalid = 1'b0;
			wvalid  = 1'b0;
			// back-pressure on B
			hold = $urandom % 4;
			repeat (hold)
			begin
				@(posedge axi_aclk);
				#2;
			end
			bready = 1'b1;
			n = 0;
			do
			begin
				@(posedge axi_aclk);
				n++;
			end
			while (!bvalid && n < TIMEOUT);
			if (!bvalid)
				report_timeout("bvalid");
			else
			begin
				compare_word("bresp", 32'h0, {30'b0, bresp});
				compare_word("bid", {31'b0, id}, {31'b0, bid});
			end
			#2;
			bready = 1'b0;
		end
	endtask

	task automatic read_reg(input logic [11:0] addr, input logic [31:0] exp, input logic id);
		int n;
		int hold;
		arid    = id;
		araddr  = addr;
		arvalid = 1'b1;
		n = 0;
		do
		begin
			@(posedge axi_aclk);
			n++;
		end
		while (!arready && n < TIMEOUT);
		if (!arready)
			report_timeout("arready");
		else
		begin
			#2;
			arvalid = 1'b0;
			hold = $urandom % 4;
			repeat (hold)
			begin
				@(posedge axi_aclk);
				#2;
			end
			rready = 1'b1;
			n = 0;
			do
			begin
				@(posedge axi_aclk);
				n++;
			end
			while (!rvalid && n < TIMEOUT);
			if (!rvalid)
				report_timeout("rvalid");
			else
			begin
				compare_word("rdata", exp, rdata);
				compare_word("rresp", 32'h0, {30'b0, rresp});
				compare_word("rlast", 32'h1, {31'b0, rlast});
				compare_word("rid", {31'b0, id}, {31'b0, rid});
			end
			#2;
			rready = 1'b0;
		end
	endtask

	// field picked by its register offset
	task automatic inspect_vq(input logic [11:0] field, input logic [31:0] exp);
		case (field)
			`VIRTIO_REG_QUEUE_READY: compare_word("vq0.ready", exp, {31'b0, vq0.ready});
			`VIRTIO_REG_DESC_LO:     compare_word("vq0.desc_lo", exp, vq0.desc_lo);
			`VIRTIO_REG_AVAIL_LO:    compare_word("vq0.avail_lo", exp, vq0.avail_lo);
			`VIRTIO_REG_USED_LO:     compare_word("vq0.used_lo", exp, vq0.used_lo);
			default:
			begin
				$display("stimulus asks for an unknown vq0 field at offset %03h", field);
				err_cnt++;
			end
		endcase
	endtask

	task automatic count_pulses(input int exp);
		int n;
		n = 0;
		while (pulse_cnt < exp && n < TIMEOUT)
		begin
			@(posedge axi_aclk);
			#2;
			n++;
		end
		if (pulse_cnt < exp)
			report_timeout("dev_req pulse");
		else
			compare_word("dev_req pulses", exp, pulse_cnt);
	endtask

	task automatic close_test(input int num);
		int errs;
		errs = err_cnt - test_err_base;
		test_cnt++;
		if (errs == 0)
			$display("test %0d passed, %0d checks", num, check_cnt - test_chk_base);
		else
		begin
			test_fail_cnt++;
			$display("test %0d failed with %0d errors", num, errs);
		end
		test_err_base = err_cnt;
		test_chk_base = check_cnt;
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		int op;
		int n;
		int cur_test;
		int tnum;
		logic [31:0] kind;
		logic [11:0] addr;
		logic [31:0] data;

		void'($urandom(32'h1441ea5b));
		awid    = '0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		arid    = '0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		err_cnt       = 0;
		check_cnt     = 0;
		test_cnt      = 0;
		test_fail_cnt = 0;
		test_err_base = 0;
		test_chk_base = 0;
		timed_out     = 1'b0;

		$readmemh("tests/virtio_mmio_stim.txt", stim_mem);

		n = 0;
		while (axi_aresetn !== 1'b1 && n < TIMEOUT)
		begin
			@(posedge axi_aclk);
			n++;
		end
		if (axi_aresetn !== 1'b1)
			report_timeout("reset release");
		@(posedge axi_aclk);
		#2;

		op = 0;
		cur_test = -1;
		while (!timed_out && op < MAX_OPS && stim_mem[4*op] != 32'h0)
		begin
			kind = stim_mem[4*op];
			addr = stim_mem[4*op+1][11:0];
			data = stim_mem[4*op+2];
			tnum = int'(stim_mem[4*op+3]);
			if (tnum != cur_test)
			begin
				if (cur_test >= 0)
					close_test(cur_test);
				cur_test = tnum;
			end
			case (kind)
				32'h1:   write_reg(addr, data, op[0]);
				32'h2:   read_reg(addr, data, op[0]);
				32'h3:   inspect_vq(addr, data);
				32'h4:   count_pulses(int'(data));
				default:
				begin
					$display("stimulus operation %0d has an unknown kind %0h", op, kind);
					err_cnt++;
				end
			endcase
			op++;
		end
		if (cur_test >= 0)
			close_test(cur_test);
		if (test_cnt == 0)
		begin
			$display("no operations were read from the stimulus file");
			err_cnt++;
		end

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			test_cnt, test_fail_cnt, check_cnt, err_cnt);
		if (err_cnt == 0 && !timed_out)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== tests/virtio_mmio_stim.txt ====
// kind address data test, kind 1 write, 2 read and compare, 3 check vq0 field
// 4 total dev_req pulses so far, 0 ends the list
1 014 00000000 01
2 000 74726976 01
2 004 00000002 01
2 008 00000002 01
2 00c ff001af4 01
2 034 00000010 01
2 100 00000004 01
2 104 00000000 01
2 0fc 00000000 01
2 010 00000000 02
1 014 00000001 02
2 010 00000003 02
1 070 00000000 03
2 070 00000001 03
1 070 00000002 03
2 070 00000003 03
1 070 00000004 03
2 070 00000003 03
1 070 00000008 03
2 070 0000000b 03
1 070 00000004 03
2 070 0000000f 03
1 070 00000000 03
2 070 00000001 03
1 070 00000002 04
1 024 00000001 04
1 020 00000003 04
2 020 00000003 04
1 070 00000008 04
1 070 00000004 04
2 070 0000000f 04
1 020 00000000 04
2 020 00000003 04
1 030 00000000 05
1 044 00000001 05
1 080 10000000 05
1 090 10001000 05
1 0a0 10002000 05
3 044 00000001 05
3 080 10000000 05
3 090 10001000 05
3 0a0 10002000 05
2 044 00000001 05
1 050 00000000 06
4 000 00000001 06
2 060 00000001 06
1 064 00000001 06
2 060 00000000 06
4 000 00000001 06
1 050 00000000 06
4 000 00000002 06
0 000 00000000 00

// ==== verilog/mmio_axi_slave.sv ====
`timescale 1ns/1ps
`include "virtio_mmio_cfg.svh"

module mmio_axi_slave (
	input  logic                        axi_aclk,
	input  logic                        axi_aresetn,
	input  logic [`VIRTIO_ID_W-1:0]     awid,
	input  logic [`VIRTIO_ADDR_W-1:0]   awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [`VIRTIO_DATA_W-1:0]   wdata,
	input  logic [`VIRTIO_DATA_W/8-1:0] wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [`VIRTIO_ID_W-1:0]     bid,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [`VIRTIO_ID_W-1:0]     arid,
	input  logic [`VIRTIO_ADDR_W-1:0]   araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [`VIRTIO_ID_W-1:0]     rid,
	output logic [`VIRTIO_DATA_W-1:0]   rdata,
	output logic [1:0]                  rresp,
	output logic                        rlast,
	output logic                        rvalid,
	input  logic                        rready,
	output virtio_mmio_pkg::reg_wr_t    wr,
	output virtio_mmio_pkg::reg_rd_t    rd,
	input  logic [`VIRTIO_DATA_W-1:0]   rd_data
);

	localparam logic [1:0] RESP_OKAY = 2'b00;

	logic wr_go;
	logic rd_go;

	// ----------------------------------------
	// write channel
	// ----------------------------------------
	// address and data are taken together, one beat only
	assign wr_go = awvalid && wvalid && !awready && !bvalid;

	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			awready <= 1'b0;
			wready  <= 1'b0;
		end
		else
		begin
			awready <= wr_go;
			wready  <= wr_go;
		end
	end

	// response held until the master takes it
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			bvalid <= 1'b0;
		else if (awready)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	always_ff @(posedge axi_aclk)
	begin
		if (awready)
			bid <= awid;
	end

	// awvalid and wvalid are still held during the ready cycle
	assign wr = '{valid: awready && wready, addr: awaddr, data: wdata};
	assign bresp = RESP_OKAY;

	// ----------------------------------------
	// read channel
	// ----------------------------------------
	// a write in the same cycle goes first
	assign rd_go = arvalid && !wr_go && !awready && !arready && !rvalid;

	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			arready <= 1'b0;
		else
			arready <= rd_go;
	end

	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			rvalid <= 1'b0;
		else if (arready)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge axi_aclk)
	begin
		if (arready)
			rid <= arid;
	end

	assign rd = '{valid: arready, addr: araddr};

	// register file only updates rd_data on a lookup, so it stays put while rvalid waits
	assign rdata = rd_data;
	assign rresp = RESP_OKAY;
	assign rlast = 1'b1;

endmodule

// ==== verilog/virtio_mmio_cfg.svh ====
`ifndef VIRTIO_MMIO_CFG_SVH
`define VIRTIO_MMIO_CFG_SVH

// bus widths
`define VIRTIO_ADDR_W          12
`define VIRTIO_DATA_W          32
`define VIRTIO_ID_W            1

// block device has a single request queue
`define VIRTIO_QUEUE_CNT       1
`define VIRTIO_QUEUE_NUM_MAX   32'd16

// ----------------------------------------
// register offsets
// ----------------------------------------
`define VIRTIO_REG_MAGIC            12'h000
`define VIRTIO_REG_VERSION          12'h004
`define VIRTIO_REG_DEVICE_ID        12'h008
`define VIRTIO_REG_VENDOR_ID        12'h00c
`define VIRTIO_REG_DEV_FEATURES     12'h010
`define VIRTIO_REG_DEV_FEATURES_SEL 12'h014
`define VIRTIO_REG_DRV_FEATURES     12'h020
`define VIRTIO_REG_DRV_FEATURES_SEL 12'h024
`define VIRTIO_REG_QUEUE_SEL        12'h030
`define VIRTIO_REG_QUEUE_NUM_MAX    12'h034
`define VIRTIO_REG_QUEUE_READY      12'h044
`define VIRTIO_REG_QUEUE_NOTIFY     12'h050
`define VIRTIO_REG_IRQ_STATUS       12'h060
`define VIRTIO_REG_IRQ_ACK          12'h064
`define VIRTIO_REG_STATUS           12'h070
`define VIRTIO_REG_DESC_LO          12'h080
`define VIRTIO_REG_DESC_HI          12'h084
`define VIRTIO_REG_AVAIL_LO         12'h090
`define VIRTIO_REG_AVAIL_HI         12'h094
`define VIRTIO_REG_USED_LO          12'h0a0
`define VIRTIO_REG_USED_HI          12'h0a4
`define VIRTIO_REG_CONFIG_GEN       12'h0fc
`define VIRTIO_REG_CAPACITY_LO      12'h100
`define VIRTIO_REG_CAPACITY_HI      12'h104

// identity, "virt" in little endian
`define VIRTIO_MAGIC           32'h7472_6976
`define VIRTIO_VERSION         32'h0000_0002
`define VIRTIO_DEVICE_ID       32'h0000_0002
`define VIRTIO_VENDOR_ID       32'hff00_1af4

// bit 32 VERSION_1, bit 33 ACCESS_PLATFORM
`define VIRTIO_DEV_FEATURES    64'h0000_0003_0000_0000
// size in 512 byte sectors
`define VIRTIO_CAPACITY        64'd4

`endif

// ==== verilog/virtio_mmio_pkg.sv ====
`include "virtio_mmio_cfg.svh"

package virtio_mmio_pkg;

	// one accepted write, valid for a single cycle
	typedef struct packed {
		logic                      valid;
		logic [`VIRTIO_ADDR_W-1:0] addr;
		logic [`VIRTIO_DATA_W-1:0] data;
	} reg_wr_t;

	// one read lookup, data comes back a cycle later
	typedef struct packed {
		logic                      valid;
		logic [`VIRTIO_ADDR_W-1:0] addr;
	} reg_rd_t;

	// ring addresses handed to the block engine
	typedef struct packed {
		logic                      ready;
		logic [`VIRTIO_DATA_W-1:0] desc_lo;
		logic [`VIRTIO_DATA_W-1:0] avail_lo;
		logic [`VIRTIO_DATA_W-1:0] used_lo;
	} vq_ring_t;

	// device status word, raw zero means reset
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [23:0] upper;
			logic        failed;
			logic        needs_reset;
			logic [1:0]  rsvd;
			logic        features_ok;
			logic        driver_ok;
			logic        driver;
			logic        ack;
		} bits;
	} dev_status_u;

	typedef enum logic [1:0] {st_reset, st_features, st_driver, st_live} setup_state_e;

endpackage

// ==== verilog/virtio_mmio_top.sv ====
`timescale 1ns/1ps
`include "virtio_mmio_cfg.svh"

module virtio_mmio_top (
	input  logic                        axi_aclk,
	input  logic                        axi_aresetn,
	input  logic [`VIRTIO_ID_W-1:0]     awid,
	input  logic [`VIRTIO_ADDR_W-1:0]   awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [`VIRTIO_DATA_W-1:0]   wdata,
	input  logic [`VIRTIO_DATA_W/8-1:0] wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [`VIRTIO_ID_W-1:0]     bid,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [`VIRTIO_ID_W-1:0]     arid,
	input  logic [`VIRTIO_ADDR_W-1:0]   araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [`VIRTIO_ID_W-1:0]     rid,
	output logic [`VIRTIO_DATA_W-1:0]   rdata,
	output logic [1:0]                  rresp,
	output logic                        rlast,
	output logic                        rvalid,
	input  logic                        rready,
	output virtio_mmio_pkg::vq_ring_t   vq0,
	output logic                        dev_req
);

	import virtio_mmio_pkg::*;

	// register side of the bus
	reg_wr_t                   wr;
	reg_rd_t                   rd;
	logic [`VIRTIO_DATA_W-1:0] rd_data;

	// setup handshake
	setup_state_e              state;
	dev_status_u               status;

	mmio_axi_slave i_axi (.*);

	virtio_status_ctrl i_status (.*);

	virtio_reg_file i_regs (.*);

endmodule

// ==== verilog/virtio_reg_file.sv ====
`timescale 1ns/1ps
`include "virtio_mmio_cfg.svh"

module virtio_reg_file (
	input  logic                          axi_aclk,
	input  logic                          axi_aresetn,
	input  virtio_mmio_pkg::reg_wr_t      wr,
	input  virtio_mmio_pkg::reg_rd_t      rd,
	input  virtio_mmio_pkg::setup_state_e state,
	input  virtio_mmio_pkg::dev_status_u  status,
	output logic [`VIRTIO_DATA_W-1:0]     rd_data,
	output virtio_mmio_pkg::vq_ring_t     vq0,
	output logic                          dev_req
);

	import virtio_mmio_pkg::*;

	localparam int          QCNT         = `VIRTIO_QUEUE_CNT;
	localparam logic [63:0] DEV_FEATURES = `VIRTIO_DEV_FEATURES;
	localparam logic [63:0] CAPACITY     = `VIRTIO_CAPACITY;

	logic [`VIRTIO_DATA_W-1:0] dev_features_sel;
	logic [`VIRTIO_DATA_W-1:0] drv_features_sel;
	logic [63:0]               drv_features;
	logic [`VIRTIO_DATA_W-1:0] queue_sel;
	logic [`VIRTIO_DATA_W-1:0] irq_status;
	logic                      irq_q;

	// per queue table, high words are kept for readback only
	vq_ring_t                  q_ring [QCNT];
	logic [`VIRTIO_DATA_W-1:0] desc_hi [QCNT];
	logic [`VIRTIO_DATA_W-1:0] avail_hi [QCNT];
	logic [`VIRTIO_DATA_W-1:0] used_hi [QCNT];

	vq_ring_t                  sel_ring;
	logic [`VIRTIO_DATA_W-1:0] sel_desc_hi;
	logic [`VIRTIO_DATA_W-1:0] sel_avail_hi;
	logic [`VIRTIO_DATA_W-1:0] sel_used_hi;
	logic [`VIRTIO_DATA_W-1:0] rd_word;

	// ----------------------------------------
	// feature, selector and interrupt registers
	// ----------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			dev_features_sel <= '0;
			drv_features_sel <= '0;
			drv_features     <= '0;
			queue_sel        <= '0;
			irq_status       <= '0;
		end
		else if (wr.valid)
		begin
			case (wr.addr)
				`VIRTIO_REG_DEV_FEATURES_SEL: dev_features_sel <= wr.data;
				`VIRTIO_REG_DRV_FEATURES_SEL: drv_features_sel <= wr.data;
				`VIRTIO_REG_QUEUE_SEL:        queue_sel <= wr.data;
				`VIRTIO_REG_DRV_FEATURES:
				begin
					// driver may only negotiate before features_ok
					if (state == st_features)
					begin
						if (drv_features_sel == '0)
							drv_features[31:0] <= wr.data;
						else
							drv_features[63:32] <= wr.data;
					end
				end
				// notify value is the queue index, only one queue here
				`VIRTIO_REG_QUEUE_NOTIFY:     irq_status[0] <= 1'b1;
				`VIRTIO_REG_IRQ_ACK:          irq_status <= irq_status & ~wr.data;
				default:                      ;
			endcase
		end
	end

	// ----------------------------------------
	// queue table
	// ----------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			for (int i = 0; i < QCNT; i++)
			begin
				q_ring[i]   <= '0;
				desc_hi[i]  <= '0;
				avail_hi[i] <= '0;
				used_hi[i]  <= '0;
			end
		end
		else if (wr.valid)
		begin
			for (int i = 0; i < QCNT; i++)
			begin
				if (queue_sel == i)
				begin
					case (wr.addr)
						`VIRTIO_REG_QUEUE_READY: q_ring[i].ready <= wr.data[0];
						`VIRTIO_REG_DESC_LO:     q_ring[i].desc_lo <= wr.data;
						`VIRTIO_REG_DESC_HI:     desc_hi[i] <= wr.data;
						`VIRTIO_REG_AVAIL_LO:    q_ring[i].avail_lo <= wr.data;
						`VIRTIO_REG_AVAIL_HI:    avail_hi[i] <= wr.data;
						`VIRTIO_REG_USED_LO:     q_ring[i].used_lo <= wr.data;
						`VIRTIO_REG_USED_HI:     used_hi[i] <= wr.data;
						default:                 ;
					endcase
				end
			end
		end
	end

	// out of range selector reads as an empty queue
	always_comb
	begin
		sel_ring     = '0;
		sel_desc_hi  = '0;
		sel_avail_hi = '0;
		sel_used_hi  = '0;
		for (int i = 0; i < QCNT; i++)
		begin
			if (queue_sel == i)
			begin
				sel_ring     = q_ring[i];
				sel_desc_hi  = desc_hi[i];
				sel_avail_hi = avail_hi[i];
				sel_used_hi  = used_hi[i];
			end
		end
	end

	assign vq0 = q_ring[0];

	// ----------------------------------------
	// read decode
	// ----------------------------------------
	always_comb
	begin
		case (rd.addr)
			`VIRTIO_REG_MAGIC:         rd_word = `VIRTIO_MAGIC;
			`VIRTIO_REG_VERSION:       rd_word = `VIRTIO_VERSION;
			`VIRTIO_REG_DEVICE_ID:     rd_word = `VIRTIO_DEVICE_ID;
			`VIRTIO_REG_VENDOR_ID:     rd_word = `VIRTIO_VENDOR_ID;
			`VIRTIO_REG_DEV_FEATURES:
				rd_word = (dev_features_sel == '0) ? DEV_FEATURES[31:0] : DEV_FEATURES[63:32];
			`VIRTIO_REG_DRV_FEATURES:
				rd_word = (drv_features_sel == '0) ? drv_features[31:0] : drv_features[63:32];
			`VIRTIO_REG_QUEUE_NUM_MAX: rd_word = `VIRTIO_QUEUE_NUM_MAX;
			`VIRTIO_REG_QUEUE_READY:   rd_word = {31'b0, sel_ring.ready};
			`VIRTIO_REG_IRQ_STATUS:    rd_word = irq_status;
			`VIRTIO_REG_STATUS:        rd_word = status.raw;
			`VIRTIO_REG_DESC_LO:       rd_word = sel_ring.desc_lo;
			`VIRTIO_REG_DESC_HI:       rd_word = sel_desc_hi;
			`VIRTIO_REG_AVAIL_LO:      rd_word = sel_ring.avail_lo;
			`VIRTIO_REG_AVAIL_HI:      rd_word = sel_avail_hi;
			`VIRTIO_REG_USED_LO:       rd_word = sel_ring.used_lo;
			`VIRTIO_REG_USED_HI:       rd_word = sel_used_hi;
			// config space never changes
			`VIRTIO_REG_CONFIG_GEN:    rd_word = '0;
			`VIRTIO_REG_CAPACITY_LO:   rd_word = CAPACITY[31:0];
			`VIRTIO_REG_CAPACITY_HI:   rd_word = CAPACITY[63:32];
			default:                   rd_word = '0;
		endcase
	end

	always_ff @(posedge axi_aclk)
	begin
		if (rd.valid)
			rd_data <= rd_word;
	end

	// request pulse on rising edge of irq bit 0
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			irq_q   <= 1'b0;
			dev_req <= 1'b0;
		end
		else
		begin
			irq_q   <= irq_status[0];
			dev_req <= irq_status[0] && !irq_q;
		end
	end

endmodule

// ==== verilog/virtio_status_ctrl.sv ====
`timescale 1ns/1ps
`include "virtio_mmio_cfg.svh"

module virtio_status_ctrl (
	input  logic                         axi_aclk,
	input  logic                         axi_aresetn,
	input  virtio_mmio_pkg::reg_wr_t     wr,
	output virtio_mmio_pkg::setup_state_e state,
	output virtio_mmio_pkg::dev_status_u  status
);

	import virtio_mmio_pkg::*;

	logic        sts_wr_q;
	dev_status_u sts_data_q;

	// latch the driver's status write
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			sts_wr_q <= 1'b0;
		else
			sts_wr_q <= wr.valid && (wr.addr == `VIRTIO_REG_STATUS);
	end

	always_ff @(posedge axi_aclk)
	begin
		if (wr.valid && (wr.addr == `VIRTIO_REG_STATUS))
			sts_data_q.raw <= wr.data;
	end

	// ----------------------------------------
	// status register
	// ----------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			status.raw <= '0;
		else if (sts_wr_q)
		begin
			// zero restarts the handshake, device acknowledges at once
			if (sts_data_q.raw == '0)
				status.raw <= 32'h0000_0001;
			else
			begin
				// only the bit this step expects is taken
				case (state)
					st_reset:    if (sts_data_q.bits.driver) status.bits.driver <= 1'b1;
					st_features: if (sts_data_q.bits.features_ok) status.bits.features_ok <= 1'b1;
					st_driver:   if (sts_data_q.bits.driver_ok) status.bits.driver_ok <= 1'b1;
					default:     ;
				endcase
			end
		end
	end

	// ----------------------------------------
	// setup sequence
	// ----------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			state <= st_reset;
		else if (sts_wr_q && (sts_data_q.raw == '0))
			state <= st_reset;
		else
		begin
			case (state)
				st_reset:    if (status.bits.driver) state <= st_features;
				st_features: if (status.bits.features_ok) state <= st_driver;
				st_driver:   if (status.bits.driver_ok) state <= st_live;
				default:     state <= st_live;
			endcase
		end
	end

endmodule
